/* logic/configure.sv */
package configure;

  localparam int xlen = 32;

  localparam logic [xlen-1:0] reset_vector_default = 32'h0000_0000;
  localparam int fetch_depth_default = 4; // must be a power of two.

  // major opcodes of the supported rv32i subset.
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_opimm = 7'b0010011;
  localparam logic [6:0] op_op = 7'b0110011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal = 7'b1101111;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] instr;
  } fetch_entry_type;

endpackage

/* logic/fetch_stage.sv */
`timescale 1ns/1ns

module fetch_stage
  import configure::*;
#(
  parameter logic [xlen-1:0] reset_vector = reset_vector_default,
  parameter int fetch_depth = fetch_depth_default
)
(
  input logic clk,
  input logic reset,
  output logic imemory_valid,
  output logic [xlen-1:0] imemory_addr,
  input logic [xlen-1:0] imemory_rdata,
  input logic imemory_ready,
  input logic [$clog2(fetch_depth):0] free_slots,
  input logic redirect,
  input logic [xlen-1:0] redirect_pc,
  output logic push,
  output fetch_entry_type push_entry
);

  logic [xlen-1:0] pc; // address of the next word to request.
  logic [xlen-1:0] req_pc;
  logic in_flight;
  logic discard;
  logic done;
  logic start;

  assign done = in_flight && imemory_ready;
  // a finishing request still holds one slot until its push lands.
  assign start = !redirect && (in_flight ? (done && free_slots > 1) : (free_slots > 0));

  assign imemory_valid = in_flight;
  assign imemory_addr = req_pc;
  assign push = done && !discard && !redirect;
  assign push_entry.pc = req_pc;
  assign push_entry.instr = imemory_rdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= reset_vector;
      in_flight <= 1'b0;
      discard <= 1'b0;
    end else begin
      if (start) begin
        in_flight <= 1'b1;
        pc <= pc + xlen'(4);
      end else if (done) begin
        in_flight <= 1'b0;
      end
      if (redirect) begin
        pc <= redirect_pc;
      end
      if (done) begin
        discard <= 1'b0;
      end else if (redirect && in_flight) begin
        discard <= 1'b1; // the word on the bus is from the old path.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      req_pc <= pc;
    end
  end

endmodule

/* logic/fetchbuffer.sv */
`timescale 1ns/1ns

module fetchbuffer
  import configure::*;
#(
  parameter int depth = fetch_depth_default
)
(
  input logic clk,
  input logic reset,
  input logic push,
  input fetch_entry_type push_entry,
  input logic pop,
  input logic flush,
  output logic pop_valid,
  output fetch_entry_type pop_entry,
  output logic [$clog2(depth):0] free_slots
);

  localparam int aw = $clog2(depth);
  localparam logic [aw:0] depth_count = (aw + 1)'(depth);

  fetch_entry_type entries [depth];
  logic [aw-1:0] rd_ptr;
  logic [aw-1:0] wr_ptr;
  logic [aw:0] count;

  assign pop_valid = count != '0;
  assign pop_entry = entries[rd_ptr];
  assign free_slots = depth_count - count;

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count <= '0; // flush wins over a push in the same cycle.
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr] <= push_entry;
    end
  end

endmodule

/* logic/register.sv */
`timescale 1ns/1ns

module register
  import configure::*;
(
  input logic clk,
  input logic reset,
  input logic [4:0] rs1_index,
  input logic [4:0] rs2_index,
  input logic [4:0] rd_index,
  input logic rd_write,
  input logic [xlen-1:0] rd_data,
  output logic [xlen-1:0] rs1_data,
  output logic [xlen-1:0] rs2_data
);

  logic [xlen-1:0] regs [31:1]; // x0 has no storage.

  assign rs1_data = (rs1_index == 5'd0) ? '0 : regs[rs1_index];
  assign rs2_data = (rs2_index == 5'd0) ? '0 : regs[rs2_index];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_write && rd_index != 5'd0) begin
      regs[rd_index] <= rd_data;
    end
  end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ns

module execute_stage
  import configure::*;
(
  input logic clk,
  input logic reset,
  input logic pop_valid,
  input fetch_entry_type pop_entry,
  output logic pop,
  output logic redirect,
  output logic [xlen-1:0] redirect_pc,
  output logic [4:0] rs1_index,
  output logic [4:0] rs2_index,
  output logic [4:0] rd_index,
  output logic rd_write,
  output logic [xlen-1:0] rd_data,
  input logic [xlen-1:0] rs1_data,
  input logic [xlen-1:0] rs2_data,
  output logic dmemory_valid,
  output logic [xlen-1:0] dmemory_addr,
  output logic [xlen-1:0] dmemory_wdata,
  output logic [3:0] dmemory_wstrb,
  input logic [xlen-1:0] dmemory_rdata,
  input logic dmemory_ready
);

  logic [31:0] instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm_u;
  logic is_lw;
  logic is_sw;
  logic is_sb;
  logic is_beq;
  logic is_bne;
  logic is_jal;
  logic is_mem;
  logic active;
  logic taken;
  logic writes_rd;
  logic [xlen-1:0] result;
  logic [xlen-1:0] target;

  assign instr = pop_entry.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd_index = instr[11:7];
  assign rs1_index = instr[19:15];
  assign rs2_index = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  assign is_lw = opcode == op_load && funct3 == 3'b010;
  assign is_sw = opcode == op_store && funct3 == 3'b010;
  assign is_sb = opcode == op_store && funct3 == 3'b000;
  assign is_beq = opcode == op_branch && funct3 == 3'b000;
  assign is_bne = opcode == op_branch && funct3 == 3'b001;
  assign is_jal = opcode == op_jal;
  assign is_mem = is_lw || is_sw || is_sb;

  // the head behind a taken branch is wrong path until the flush lands.
  assign active = pop_valid && !redirect;
  assign pop = active && (!is_mem || dmemory_ready);

  always_comb begin
    writes_rd = 1'b0;
    result = '0;
    case (opcode)
      op_lui: begin
        writes_rd = 1'b1;
        result = imm_u;
      end
      op_opimm: begin
        writes_rd = funct3 == 3'b000; // addi only.
        result = rs1_data + imm_i;
      end
      op_op: begin
        writes_rd = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: result = rs1_data + rs2_data;
          10'b0100000_000: result = rs1_data - rs2_data;
          10'b0000000_111: result = rs1_data & rs2_data;
          10'b0000000_110: result = rs1_data | rs2_data;
          10'b0000000_100: result = rs1_data ^ rs2_data;
          default: writes_rd = 1'b0;
        endcase
      end
      op_load: begin
        writes_rd = is_lw;
        result = dmemory_rdata;
      end
      op_jal: begin
        writes_rd = 1'b1;
        result = pop_entry.pc + xlen'(4);
      end
      default: ;
    endcase
  end

  assign rd_write = pop && writes_rd;
  assign rd_data = result;

  assign taken = is_jal || (is_beq && rs1_data == rs2_data) || (is_bne && rs1_data != rs2_data);
  assign target = pop_entry.pc + (is_jal ? imm_j : imm_b);

  assign dmemory_valid = active && is_mem;
  assign dmemory_addr = rs1_data + (opcode == op_store ? imm_s : imm_i);
  assign dmemory_wdata = is_sb ? {4{rs2_data[7:0]}} : rs2_data;
  assign dmemory_wstrb = is_sw ? 4'b1111 : (is_sb ? (4'b0001 << dmemory_addr[1:0]) : 4'b0000);

  always_ff @(posedge clk) begin
    if (reset) begin
      redirect <= 1'b0;
    end else begin
      redirect <= pop && taken;
    end
  end

  always_ff @(posedge clk) begin
    if (pop && taken) begin
      redirect_pc <= target;
    end
  end

endmodule

/* logic/cpu.sv */
`timescale 1ns/1ns

module cpu
  import configure::*;
#(
  parameter logic [xlen-1:0] reset_vector = reset_vector_default,
  parameter int fetch_depth = fetch_depth_default
)
(
  input logic clk,
  input logic reset,
  output logic imemory_valid,
  output logic [xlen-1:0] imemory_addr,
  output logic [xlen-1:0] imemory_wdata,
  output logic [3:0] imemory_wstrb,
  input logic [xlen-1:0] imemory_rdata,
  input logic imemory_ready,
  output logic dmemory_valid,
  output logic [xlen-1:0] dmemory_addr,
  output logic [xlen-1:0] dmemory_wdata,
  output logic [3:0] dmemory_wstrb,
  input logic [xlen-1:0] dmemory_rdata,
  input logic dmemory_ready
);

  logic push;
  fetch_entry_type push_entry;
  logic [$clog2(fetch_depth):0] free_slots;
  logic pop;
  logic pop_valid;
  fetch_entry_type pop_entry;
  logic redirect;
  logic [xlen-1:0] redirect_pc;
  logic [4:0] rs1_index;
  logic [4:0] rs2_index;
  logic [4:0] rd_index;
  logic rd_write;
  logic [xlen-1:0] rd_data;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;

  assign imemory_wdata = '0; // the instruction port only reads.
  assign imemory_wstrb = '0;

  fetch_stage #(
    .reset_vector (reset_vector),
    .fetch_depth (fetch_depth)
  ) fetch_stage_comp (
    .clk (clk),
    .reset (reset),
    .imemory_valid (imemory_valid),
    .imemory_addr (imemory_addr),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .free_slots (free_slots),
    .redirect (redirect),
    .redirect_pc (redirect_pc),
    .push (push),
    .push_entry (push_entry)
  );

  fetchbuffer #(
    .depth (fetch_depth)
  ) fetchbuffer_comp (
    .clk (clk),
    .reset (reset),
    .push (push),
    .push_entry (push_entry),
    .pop (pop),
    .flush (redirect),
    .pop_valid (pop_valid),
    .pop_entry (pop_entry),
    .free_slots (free_slots)
  );

  register register_comp (
    .clk (clk),
    .reset (reset),
    .rs1_index (rs1_index),
    .rs2_index (rs2_index),
    .rd_index (rd_index),
    .rd_write (rd_write),
    .rd_data (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  execute_stage execute_stage_comp (
    .clk (clk),
    .reset (reset),
    .pop_valid (pop_valid),
    .pop_entry (pop_entry),
    .pop (pop),
    .redirect (redirect),
    .redirect_pc (redirect_pc),
    .rs1_index (rs1_index),
    .rs2_index (rs2_index),
    .rd_index (rd_index),
    .rd_write (rd_write),
    .rd_data (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .dmemory_valid (dmemory_valid),
    .dmemory_addr (dmemory_addr),
    .dmemory_wdata (dmemory_wdata),
    .dmemory_wstrb (dmemory_wstrb),
    .dmemory_rdata (dmemory_rdata),
    .dmemory_ready (dmemory_ready)
  );

endmodule

/* tb/cpu_asserts.sv */
`timescale 1ns/1ns

module cpu_asserts (
  input logic clk,
  input logic reset,
  input logic imemory_valid,
  input logic [31:0] imemory_addr,
  input logic [3:0] imemory_wstrb,
  input logic imemory_ready,
  input logic dmemory_valid,
  input logic [31:0] dmemory_addr,
  input logic dmemory_ready,
  input logic push,
  input logic buffer_full
);

  imem_hold: assert property (@(posedge clk) disable iff (reset)
    imemory_valid && !imemory_ready |=> imemory_valid && $stable(imemory_addr))
    else $error("instruction request changed before ready");

  dmem_hold: assert property (@(posedge clk) disable iff (reset)
    dmemory_valid && !dmemory_ready |=> dmemory_valid && $stable(dmemory_addr))
    else $error("data request changed before ready");

  imem_read_only: assert property (@(posedge clk) imemory_wstrb == 4'b0000)
    else $error("instruction port issued a write strobe");

  no_overflow: assert property (@(posedge clk) disable iff (reset) push |-> !buffer_full)
    else $error("fetch pushed into a full buffer");

  // the cycle after a reset edge starts with both ports idle.
  idle_after_reset: assert property (@(posedge clk) reset |=> !imemory_valid && !dmemory_valid)
    else $error("memory request active right after reset");

endmodule

bind cpu cpu_asserts asserts_comp (
  .clk (clk),
  .reset (reset),
  .imemory_valid (imemory_valid),
  .imemory_addr (imemory_addr),
  .imemory_wstrb (imemory_wstrb),
  .imemory_ready (imemory_ready),
  .dmemory_valid (dmemory_valid),
  .dmemory_addr (dmemory_addr),
  .dmemory_ready (dmemory_ready),
  .push (push),
  .buffer_full (free_slots == '0)
);

/* tb/cpu_tb.sv */
`timescale 1ns/1ns

module cpu_tb;

  localparam int period = 20;
  localparam int num_runs = 6;

  logic clk = 1'b0;
  logic reset;
  logic imemory_valid;
  logic [31:0] imemory_addr;
  logic [31:0] imemory_wdata;
  logic [3:0] imemory_wstrb;
  logic [31:0] imemory_rdata;
  logic imemory_ready;
  logic dmemory_valid;
  logic [31:0] dmemory_addr;
  logic [31:0] dmemory_wdata;
  logic [3:0] dmemory_wstrb;
  logic [31:0] dmemory_rdata;
  logic dmemory_ready;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  logic [31:0] log_addr [$];
  logic [31:0] log_strb [$];
  logic [31:0] log_data [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_strb [$];
  logic [31:0] exp_data [$];
  string test_name;
  int prog_len;
  int imem_wait = 0;
  int dmem_wait = 0;
  bit slow = 1'b0; // random wait cycles on both ports.
  integer seed = 32'h4c085970;

  cpu uut (
    .clk (clk),
    .reset (reset),
    .imemory_valid (imemory_valid),
    .imemory_addr (imemory_addr),
    .imemory_wdata (imemory_wdata),
    .imemory_wstrb (imemory_wstrb),
    .imemory_rdata (imemory_rdata),
    .imemory_ready (imemory_ready),
    .dmemory_valid (dmemory_valid),
    .dmemory_addr (dmemory_addr),
    .dmemory_wdata (dmemory_wdata),
    .dmemory_wstrb (dmemory_wstrb),
    .dmemory_rdata (dmemory_rdata),
    .dmemory_ready (dmemory_ready)
  );

  always #(period / 2) clk = ~clk;

  // instruction and data responders draw from one random stream.
  always @(posedge clk) begin
    #1;
    imemory_ready = 1'b0;
    dmemory_ready = 1'b0;
    if (imemory_valid === 1'b1) begin
      if (imem_wait == 0) begin
        check("instruction write data", 32'h0, imemory_wdata);
        imemory_ready = 1'b1;
        imemory_rdata = imem[imemory_addr[9:2]];
        imem_wait = slow ? ($random(seed) & 3) : 0;
      end else begin
        imem_wait = imem_wait - 1;
      end
    end
    if (dmemory_valid === 1'b1) begin
      if (dmem_wait == 0) begin
        dmemory_ready = 1'b1;
        dmemory_rdata = dmem[dmemory_addr[9:2]];
        if (dmemory_wstrb != 4'b0000) begin
          log_addr.push_back(dmemory_addr);
          log_strb.push_back({28'b0, dmemory_wstrb});
          log_data.push_back(dmemory_wdata);
          for (int b = 0; b < 4; b++) begin
            if (dmemory_wstrb[b]) begin
              dmem[dmemory_addr[9:2]][8*b +: 8] = dmemory_wdata[8*b +: 8];
            end
          end
        end
        dmem_wait = slow ? ($random(seed) & 3) : 0;
      end else begin
        dmem_wait = dmem_wait - 1;
      end
    end
  end

  function automatic logic [31:0] lui(input int rd, input int imm);
    return {imm[19:0], rd[4:0], 7'h37};
  endfunction

  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h13};
  endfunction

  function automatic logic [31:0] alu(input int f7, input int f3, input int rd, input int rs1,
                                      input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'h03};
  endfunction

  function automatic logic [31:0] store(input int f3, input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] branch(input int f3, input int rs1, input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] jal(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[prog_len] = word;
    prog_len++;
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] strb,
                              input logic [31:0] data);
    exp_addr.push_back(addr);
    exp_strb.push_back(strb);
    exp_data.push_back(data);
  endtask

  task automatic check(input string what, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: %s expected %h actual %h", test_name, what, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic begin_test(input string name, input bit latency);
    test_name = name;
    slow = latency;
    @(posedge clk);
    #1;
    reset = 1'b1;
    @(posedge clk);
    prog_len = 0;
    exp_addr.delete();
    exp_strb.delete();
    exp_data.delete();
    for (int i = 0; i < 256; i++) begin
      imem[i] = {i[24:0], 7'h0b}; // custom-0 opcode, retires as a no-op.
      dmem[i] = 32'hc0de_0000 | i;
    end
  endtask

  task automatic run_program();
    repeat (7) @(posedge clk);
    #1;
    log_addr.delete();
    log_strb.delete();
    log_data.delete();
    reset = 1'b0;
    while (log_addr.size() < exp_addr.size()) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk); // window for stray stores after the last one.
    check("store count", exp_addr.size(), log_addr.size());
    for (int i = 0; i < exp_addr.size(); i++) begin
      check("store address", exp_addr[i], log_addr[i]);
      check("store strobe", exp_strb[i], log_strb[i]);
      check("store data", exp_data[i], log_data[i]);
    end
  endtask

  task automatic alu_test(input string name, input bit latency);
    logic [31:0] v [1:8];
    begin_test(name, latency);
    v[1] = {20'h12345, 12'h000} + 32'h678;
    v[2] = 0 - 5;
    v[3] = v[2] - 2048;
    v[4] = v[1] + v[2];
    v[5] = v[2] - v[1];
    v[6] = v[1] & v[3];
    v[7] = v[1] | v[2];
    v[8] = v[1] ^ v[3];
    emit(lui(1, 'h12345));
    emit(addi(1, 1, 'h678));
    emit(addi(2, 0, -5));
    emit(addi(3, 2, -2048));
    emit(alu(0, 0, 4, 1, 2));
    emit(alu('h20, 0, 5, 2, 1));
    emit(alu(0, 7, 6, 1, 3));
    emit(alu(0, 6, 7, 1, 2));
    emit(alu(0, 4, 8, 1, 3));
    emit(addi(0, 0, 7));
    emit(alu(0, 0, 0, 1, 1));
    for (int i = 1; i <= 8; i++) begin
      emit(store(2, i, 0, 'h40 + 4 * (i - 1)));
      expect_store('h40 + 4 * (i - 1), 'hf, v[i]);
    end
    emit(store(2, 0, 0, 'h60));
    expect_store('h60, 'hf, 0);
    emit(jal(0, 0));
    run_program();
  endtask

  task automatic load_test(input string name);
    logic [31:0] preset;
    begin_test(name, 1'b0);
    preset = 32'h7fff_fff0;
    dmem[32] = preset; // byte address 0x80.
    emit(addi(1, 0, 'h80));
    emit(addi(2, 0, 'h25));
    emit(lw(3, 1, 0));
    emit(alu(0, 0, 4, 3, 2));
    emit(store(2, 4, 1, 4));
    emit(lw(5, 1, 4));
    emit(addi(5, 5, 1));
    emit(store(2, 5, 1, 8));
    emit(jal(0, 0));
    expect_store('h84, 'hf, preset + 'h25);
    expect_store('h88, 'hf, preset + 'h26);
    run_program();
  endtask

  task automatic control_test(input string name, input bit latency);
    logic [31:0] link;
    begin_test(name, latency);
    emit(addi(9, 0, 'h7ad)); // marker that a skipped store would write.
    emit(addi(1, 0, 5));
    emit(addi(2, 0, 5));
    emit(addi(3, 0, 7));
    emit(branch(0, 1, 2, 8));
    emit(store(2, 9, 0, 'h40));
    emit(store(2, 1, 0, 'h44));
    expect_store('h44, 'hf, 5);
    emit(branch(0, 1, 3, 8));
    emit(store(2, 3, 0, 'h48));
    expect_store('h48, 'hf, 7);
    emit(branch(1, 1, 3, 8));
    emit(store(2, 9, 0, 'h40));
    emit(branch(1, 1, 2, 8));
    emit(store(2, 2, 0, 'h4c));
    expect_store('h4c, 'hf, 5);
    link = 4 * prog_len + 4;
    emit(jal(5, 12));
    emit(store(2, 9, 0, 'h40));
    emit(store(2, 9, 0, 'h40));
    emit(store(2, 5, 0, 'h50));
    expect_store('h50, 'hf, link);
    emit(jal(0, 0));
    run_program();
  endtask

  task automatic byte_store_test(input string name);
    logic [31:0] word;
    logic [7:0] b;
    begin_test(name, 1'b0);
    emit(addi(1, 0, 'h100));
    for (int k = 0; k < 4; k++) begin
      b = 8'('h81 + 'h22 * k);
      emit(addi(2, 0, 'h81 + 'h22 * k));
      emit(store(0, 2, 1, 5 * k));
      expect_store('h100 + 5 * k, 1 << k, {4{b}});
    end
    for (int k = 0; k < 4; k++) begin
      b = 8'('h81 + 'h22 * k);
      word = 32'hc0de_0000 | (64 + k);
      word[8*k +: 8] = b;
      emit(lw(3, 1, 4 * k));
      emit(store(2, 3, 1, 'h40 + 4 * k));
      expect_store('h140 + 4 * k, 'hf, word);
    end
    emit(jal(0, 0));
    run_program();
  endtask

  initial begin
    reset = 1'b1;
    imemory_ready = 1'b0;
    imemory_rdata = '0;
    dmemory_ready = 1'b0;
    dmemory_rdata = '0;
    alu_test("alu", 1'b0);
    load_test("load");
    control_test("control", 1'b0);
    byte_store_test("byte stores");
    alu_test("alu with latency", 1'b1);
    control_test("control with latency", 1'b1);
    $display("PASS: all tests");
    $finish;
  end

  initial begin
    #(num_runs * 200 * period);
    $display("timeout: the core stopped making progress");
    $display("FAIL: see errors above");
    $fatal(1);
  end

endmodule

/* flist.f */
logic/configure.sv
logic/fetch_stage.sv
logic/fetchbuffer.sv
logic/register.sv
logic/execute_stage.sv
logic/cpu.sv
tb/cpu_asserts.sv
tb/cpu_tb.sv

/* run.sh */
#!/bin/sh
# Build the cpu testbench with Verilator and run it; exit status reflects the result.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module cpu_tb -o cpu_sim \
  && ./obj_dir/cpu_sim > sim.log 2>&1 \
  && ! grep -q "FAIL: see errors above" sim.log \
  && echo "simulation passed" \
  || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
